//--- tb.f
+incdir+src
src/rv32i_isa_pkg.sv
src/exec_ctrl_pkg.sv
src/exec_decode.sv
src/exec_reg_file.sv
src/exec_alu.sv
src/branch_jump_unit.sv
src/execute_stage.sv
dv/execute_stage_properties.sv
dv/execute_stage_tb.sv

//--- Makefile
TOP := execute_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- dv/execute_stage_tb.sv
// Execute stage testbench
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module execute_stage_tb;
    import rv32i_isa_pkg::*;

    localparam int NUM_CYCLES = 6000;

    logic                  CLK = 1'b0;
    logic                  nRST;
    logic                  fetch_valid, ex_mem_stall, ex_mem_flush, fwd_rs1, fwd_rs2, wb_en;
    logic [`WORD_W-1:0]    fetch_instr, fetch_pc, fwd_data, wb_data;
    logic [`REG_IDX_W-1:0] wb_rd, rs1_e, rs2_e, mem_rd;
    logic                  mem_valid, mem_reg_write, mem_dren, mem_dwen;
    logic                  mem_branch, mem_jump, mem_branch_taken, mem_illegal;
    logic [`WORD_W-1:0]    mem_pc, mem_port_out, mem_rs2_data, mem_brj_addr;

    // Shadow register file and the write that lands on the next edge
    logic [`WORD_W-1:0]    shadow [`NUM_REGS];
    logic                  pend_wen;
    logic [`REG_IDX_W-1:0] pend_rd;
    logic [`WORD_W-1:0]    pend_data;

    // Expected pipeline register contents
    logic                  e_valid, e_rw, e_dren, e_dwen, e_branch, e_jump, e_taken, e_illegal;
    logic                  e_out_known;
    logic [`WORD_W-1:0]    e_pc, e_out, e_rs2, e_brj;
    logic [`REG_IDX_W-1:0] e_rd;

    always #5 CLK = ~CLK;

    execute_stage execute_stage_inst (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic clear_expected();
        {e_valid, e_rw, e_dren, e_dwen, e_branch, e_jump, e_taken, e_illegal} = '0;
        {e_pc, e_out, e_rs2, e_brj, e_rd} = '0;
        e_out_known = 1'b1;
    endtask

    task automatic compare_outputs();
        // Index outputs follow the instruction still on the fetch inputs
        check("rs1_e", 32'(rs1_e), 32'(fetch_instr[19:15]));
        check("rs2_e", 32'(rs2_e), 32'(fetch_instr[24:20]));
        check("mem_valid", 32'(mem_valid), 32'(e_valid));
        check("mem_pc", mem_pc, e_pc);
        if (e_out_known) begin
            check("mem_port_out", mem_port_out, e_out);
        end
        check("mem_rs2_data", mem_rs2_data, e_rs2);
        check("mem_rd", 32'(mem_rd), 32'(e_rd));
        check("mem_reg_write", 32'(mem_reg_write), 32'(e_rw));
        check("mem_dren", 32'(mem_dren), 32'(e_dren));
        check("mem_dwen", 32'(mem_dwen), 32'(e_dwen));
        check("mem_branch", 32'(mem_branch), 32'(e_branch));
        check("mem_jump", 32'(mem_jump), 32'(e_jump));
        check("mem_branch_taken", 32'(mem_branch_taken), 32'(e_taken));
        check("mem_brj_addr", mem_brj_addr, e_brj);
        check("mem_illegal", 32'(mem_illegal), 32'(e_illegal));
    endtask

    // Random legal instruction with about 1 in 16 given a bad opcode
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $urandom;
        f3 = r[14:12];
        if ($urandom_range(15, 0) == 0) begin
            // Low opcode bits other than 2'b11 never decode
            return {r[31:7], r[6:2], 1'b0, r[0]};
        end
        case ($urandom_range(8, 0))
            0: return {r[31:7], LUI};
            1: return {r[31:7], AUIPC};
            2: return {r[31:7], JAL};
            3: return {r[31:15], 3'b000, r[11:7], JALR};
            // Skip the two unused branch funct3 codes
            4: return {r[31:15], r[14], r[14] & r[13], r[12], r[11:7], BRANCH};
            5: return {r[31:7], LOAD};
            6: return {r[31:7], STORE};
            7: begin
                f7 = (f3 == 3'b001) ? 7'h00 : (f3 == 3'b101) ? {1'b0, r[30], 5'h00} : r[31:25];
                return {f7, r[24:7], OP_IMM};
            end
            default: begin
                f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[30], 5'h00} : 7'h00;
                return {f7, r[24:7], OP};
            end
        endcase
    endfunction

    task automatic drive_idle();
        {fetch_valid, ex_mem_stall, ex_mem_flush, fwd_rs1, fwd_rs2, wb_en} = '0;
        {fetch_instr, fetch_pc, fwd_data, wb_data} = '0;
        wb_rd = '0;
    endtask

    task automatic drive_random();
        fetch_valid  = ($urandom_range(7, 0) != 0);
        fetch_instr  = random_instr();
        fetch_pc     = $urandom & 32'hffff_fffc;
        ex_mem_stall = ($urandom_range(7, 0) == 0);
        ex_mem_flush = ($urandom_range(7, 0) == 0);
        fwd_rs1      = ($urandom_range(3, 0) == 0);
        fwd_rs2      = ($urandom_range(3, 0) == 0);
        fwd_data     = $urandom;
        wb_en        = ($urandom_range(1, 0) == 1);
        wb_rd        = 5'($urandom);
        wb_data      = $urandom;
    endtask

    // Next pipeline register contents from the RV32I rules
    task automatic predict();
        opcode_t            op;
        logic [2:0]         f3;
        logic               cond;
        logic [`WORD_W-1:0] a, b, bsrc, ii, si, ui, bi, ji, res, jt;
        // Writes are dropped under stall and x0 never changes
        pend_wen  = wb_en && !ex_mem_stall && wb_rd != '0;
        pend_rd   = wb_rd;
        pend_data = wb_data;
        if (ex_mem_flush && !ex_mem_stall) begin
            clear_expected();
        end else if (!ex_mem_stall) begin
            op = opcode_t'(fetch_instr[6:0]);
            f3 = fetch_instr[14:12];
            // Reads see the old contents unless forwarded
            a  = fwd_rs1 ? fwd_data : shadow[fetch_instr[19:15]];
            b  = fwd_rs2 ? fwd_data : shadow[fetch_instr[24:20]];
            ii = 32'($signed(fetch_instr[31:20]));
            si = 32'($signed({fetch_instr[31:25], fetch_instr[11:7]}));
            ui = {fetch_instr[31:12], 12'h000};
            bi = 32'($signed({fetch_instr[31], fetch_instr[7], fetch_instr[30:25],
                              fetch_instr[11:8], 1'b0}));
            ji = 32'($signed({fetch_instr[31], fetch_instr[19:12], fetch_instr[20],
                              fetch_instr[30:21], 1'b0}));
            bsrc = (op == OP) ? b : ii;
            case (f3)
                3'b000:  res = (op == OP && fetch_instr[30]) ? a - bsrc : a + bsrc;
                3'b001:  res = a << bsrc[4:0];
                3'b010:  res = 32'($signed(a) < $signed(bsrc));
                3'b011:  res = 32'(a < bsrc);
                3'b100:  res = a ^ bsrc;
                3'b101:  res = fetch_instr[30] ? 32'($signed(a) >>> bsrc[4:0]) : a >> bsrc[4:0];
                3'b110:  res = a | bsrc;
                default: res = a & bsrc;
            endcase
            case (f3)
                3'b000:  cond = (a == b);
                3'b001:  cond = (a != b);
                3'b100:  cond = $signed(a) < $signed(b);
                3'b101:  cond = $signed(a) >= $signed(b);
                3'b110:  cond = a < b;
                default: cond = a >= b;
            endcase
            e_illegal = !(op inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP});
            e_rw      = op inside {LUI, AUIPC, JAL, JALR, LOAD, OP_IMM, OP};
            e_dren    = (op == LOAD);
            e_dwen    = (op == STORE);
            e_branch  = (op == BRANCH);
            e_jump    = (op == JAL) || (op == JALR);
            e_taken   = e_branch && cond;
            case (op)
                LUI:       e_out = ui;
                AUIPC:     e_out = fetch_pc + ui;
                JAL, JALR: e_out = fetch_pc + 4;
                LOAD:      e_out = a + ii;
                STORE:     e_out = a + si;
                default:   e_out = res;
            endcase
            // ALU result of a branch or illegal op is undefined
            e_out_known = !(e_branch || e_illegal);
            jt    = (op == JAL) ? fetch_pc + ji : ((a + ii) & ~32'd1);
            e_brj = e_jump ? jt : (e_taken ? fetch_pc + bi : fetch_pc + 4);
            e_valid = fetch_valid;
            e_pc    = fetch_pc;
            e_rs2   = b;
            e_rd    = fetch_instr[11:7];
        end
    endtask

    // Hold reset for two edges then expect cleared outputs
    task automatic reset_dut();
        drive_idle();
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        pend_wen = 1'b0;
        clear_expected();
        nRST = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(posedge CLK);
        end
        #1;
        compare_outputs();
        nRST = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h72343a34));
        nRST = 1'b0;
        drive_idle();
        reset_dut();
        for (int n = 0; n < NUM_CYCLES; n++) begin
            // Second reset in the middle of traffic
            if (n == NUM_CYCLES / 2) begin
                reset_dut();
            end
            drive_random();
            predict();
            @(posedge CLK);
            #1;
            compare_outputs();
            if (pend_wen) begin
                shadow[pend_rd] = pend_data;
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/execute_stage_properties.sv
// Pipeline register assertions
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module execute_stage_properties (
    input logic                              CLK,
    input logic                              nRST,
    input logic                              ex_mem_stall,
    input logic                              ex_mem_flush,
    input logic                              mem_valid,
    input logic                              mem_illegal,
    input logic                              mem_reg_write,
    input logic                              mem_dren,
    input logic                              mem_dwen,
    input logic [4*`WORD_W+`REG_IDX_W+7:0]   mem_state
);
    // Whole register held under stall
    assert property (@(posedge CLK) disable iff (!nRST) ex_mem_stall |=> $stable(mem_state))
        else $error("stall did not hold the pipeline register");

    assert property (@(posedge CLK) disable iff (!nRST)
        ex_mem_flush && !ex_mem_stall |=> !mem_valid)
        else $error("flush did not clear mem_valid");

    // Squashed instruction carries no side effects
    assert property (@(posedge CLK) disable iff (!nRST)
        mem_illegal |-> !mem_reg_write && !mem_dren && !mem_dwen)
        else $error("illegal instruction left a control bit set");

endmodule

bind execute_stage execute_stage_properties props_inst (
    .CLK, .nRST, .ex_mem_stall, .ex_mem_flush, .mem_valid, .mem_illegal,
    .mem_reg_write, .mem_dren, .mem_dwen,
    .mem_state({mem_valid, mem_pc, mem_port_out, mem_rs2_data, mem_rd, mem_reg_write, mem_dren,
                mem_dwen, mem_branch, mem_jump, mem_branch_taken, mem_brj_addr, mem_illegal})
);

//--- src/execute_stage.sv
// RV32I execute stage
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module execute_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  fetch_valid,
    input  logic [`WORD_W-1:0]    fetch_instr,
    input  logic [`WORD_W-1:0]    fetch_pc,
    input  logic                  ex_mem_stall,
    input  logic                  ex_mem_flush,
    input  logic                  fwd_rs1,
    input  logic                  fwd_rs2,
    input  logic [`WORD_W-1:0]    fwd_data,
    input  logic                  wb_en,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic [`WORD_W-1:0]    wb_data,
    output logic [`REG_IDX_W-1:0] rs1_e,
    output logic [`REG_IDX_W-1:0] rs2_e,
    output logic                  mem_valid,
    output logic [`WORD_W-1:0]    mem_pc,
    output logic [`WORD_W-1:0]    mem_port_out,
    output logic [`WORD_W-1:0]    mem_rs2_data,
    output logic [`REG_IDX_W-1:0] mem_rd,
    output logic                  mem_reg_write,
    output logic                  mem_dren,
    output logic                  mem_dwen,
    output logic                  mem_branch,
    output logic                  mem_jump,
    output logic                  mem_branch_taken,
    output logic [`WORD_W-1:0]    mem_brj_addr,
    output logic                  mem_illegal
);
    import rv32i_isa_pkg::*;
    import exec_ctrl_pkg::*;

    logic [`REG_IDX_W-1:0] rd;
    alu_op_t               alu_op;
    alu_a_sel_t            alu_a_sel;
    alu_b_sel_t            alu_b_sel;
    branch_cond_t          branch_cond;
    logic [`WORD_W-1:0]    imm_i, imm_s, imm_u, imm_b, imm_j;
    logic                  reg_write, dren, dwen, branch, jump, j_sel, illegal;
    logic [`WORD_W-1:0]    rs1_data, rs2_data;
    logic [`WORD_W-1:0]    rs1_fwd, rs2_fwd;
    logic [`WORD_W-1:0]    port_a, port_b, alu_out, ex_out;
    logic                  branch_taken;
    logic [`WORD_W-1:0]    brj_addr;

    exec_decode decode_inst (
        .instr(fetch_instr), .rs1(rs1_e), .rs2(rs2_e), .rd,
        .alu_op, .alu_a_sel, .alu_b_sel, .branch_cond,
        .imm_i, .imm_s, .imm_u, .imm_b, .imm_j,
        .reg_write, .dren, .dwen, .branch, .jump, .j_sel, .illegal
    );

    // Writeback drops while the pipe is held
    exec_reg_file reg_file_inst (
        .CLK, .nRST, .rs1(rs1_e), .rs2(rs2_e), .rs1_data, .rs2_data,
        .wen(wb_en && !ex_mem_stall), .rd(wb_rd), .w_data(wb_data)
    );

    // Forwarded value wins over the register file
    assign rs1_fwd = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_fwd = fwd_rs2 ? fwd_data : rs2_data;

    always_comb begin
        case (alu_a_sel)
            RS1:     port_a = rs1_fwd;
            PC:      port_a = fetch_pc;
            default: port_a = '0;
        endcase
        case (alu_b_sel)
            RS2:     port_b = rs2_fwd;
            IMM_I:   port_b = imm_i;
            IMM_S:   port_b = imm_s;
            default: port_b = imm_u;
        endcase
    end

    exec_alu alu_inst (.alu_op, .port_a, .port_b, .port_out(alu_out));

    branch_jump_unit bju_inst (
        .branch_cond, .rs1_data(rs1_fwd), .rs2_data(rs2_fwd), .pc(fetch_pc),
        .imm_b, .imm_i, .imm_j, .jump, .j_sel, .branch, .branch_taken, .brj_addr
    );

    // Jumps write the link address pc+4
    assign ex_out = jump ? (fetch_pc + `WORD_W'(4)) : alu_out;

    // Stall holds, flush clears, illegal squashes control
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_valid        <= 1'b0;
            mem_pc           <= '0;
            mem_port_out     <= '0;
            mem_rs2_data     <= '0;
            mem_rd           <= '0;
            mem_reg_write    <= 1'b0;
            mem_dren         <= 1'b0;
            mem_dwen         <= 1'b0;
            mem_branch       <= 1'b0;
            mem_jump         <= 1'b0;
            mem_branch_taken <= 1'b0;
            mem_brj_addr     <= '0;
            mem_illegal      <= 1'b0;
        end else if (!ex_mem_stall) begin
            if (ex_mem_flush) begin
                mem_valid        <= 1'b0;
                mem_pc           <= '0;
                mem_port_out     <= '0;
                mem_rs2_data     <= '0;
                mem_rd           <= '0;
                mem_reg_write    <= 1'b0;
                mem_dren         <= 1'b0;
                mem_dwen         <= 1'b0;
                mem_branch       <= 1'b0;
                mem_jump         <= 1'b0;
                mem_branch_taken <= 1'b0;
                mem_brj_addr     <= '0;
                mem_illegal      <= 1'b0;
            end else begin
                // Valid passes through even when illegal
                mem_valid        <= fetch_valid;
                mem_pc           <= fetch_pc;
                mem_port_out     <= ex_out;
                mem_rs2_data     <= rs2_fwd;
                mem_rd           <= rd;
                mem_reg_write    <= reg_write && !illegal;
                mem_dren         <= dren && !illegal;
                mem_dwen         <= dwen && !illegal;
                mem_branch       <= branch && !illegal;
                mem_jump         <= jump && !illegal;
                mem_branch_taken <= branch_taken;
                mem_brj_addr     <= brj_addr;
                mem_illegal      <= illegal;
            end
        end
    end

endmodule

//--- src/branch_jump_unit.sv
// Branch and jump resolution
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module branch_jump_unit (
    input  rv32i_isa_pkg::branch_cond_t branch_cond,
    input  logic [`WORD_W-1:0]          rs1_data,
    input  logic [`WORD_W-1:0]          rs2_data,
    input  logic [`WORD_W-1:0]          pc,
    input  logic [`WORD_W-1:0]          imm_b,
    input  logic [`WORD_W-1:0]          imm_i,
    input  logic [`WORD_W-1:0]          imm_j,
    input  logic                        jump,
    input  logic                        j_sel,
    input  logic                        branch,
    output logic                        branch_taken,
    output logic [`WORD_W-1:0]          brj_addr
);
    import rv32i_isa_pkg::*;

    logic               cond_true;
    logic [`WORD_W-1:0] pc4;
    logic [`WORD_W-1:0] branch_target;
    logic [`WORD_W-1:0] jalr_sum;
    logic [`WORD_W-1:0] jump_target;

    // Compare on forwarded operands
    always_comb begin
        case (branch_cond)
            BEQ:     cond_true = (rs1_data == rs2_data);
            BNE:     cond_true = (rs1_data != rs2_data);
            BLT:     cond_true = $signed(rs1_data) < $signed(rs2_data);
            BGE:     cond_true = $signed(rs1_data) >= $signed(rs2_data);
            BLTU:    cond_true = rs1_data < rs2_data;
            BGEU:    cond_true = rs1_data >= rs2_data;
            default: cond_true = 1'b0;
        endcase
    end

    assign branch_taken  = branch & cond_true;
    assign pc4           = pc + `WORD_W'(4);
    assign branch_target = pc + imm_b;

    // JAL is PC relative, JALR clears bit 0
    assign jalr_sum    = rs1_data + imm_i;
    assign jump_target = j_sel ? (pc + imm_j) : {jalr_sum[`WORD_W-1:1], 1'b0};

    // Jump first, then taken branch, else fall through
    assign brj_addr = jump ? jump_target : (branch_taken ? branch_target : pc4);

endmodule

//--- src/exec_alu.sv
// RV32I integer ALU
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module exec_alu (
    input  exec_ctrl_pkg::alu_op_t alu_op,
    input  logic [`WORD_W-1:0]     port_a,
    input  logic [`WORD_W-1:0]     port_b,
    output logic [`WORD_W-1:0]     port_out
);
    import exec_ctrl_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // Only the low five bits shift
    assign shamt = port_b[4:0];
    assign lt_s  = $signed(port_a) < $signed(port_b);
    assign lt_u  = port_a < port_b;

    always_comb begin
        case (alu_op)
            ADD:     port_out = port_a + port_b;
            SUB:     port_out = port_a - port_b;
            SLL:     port_out = port_a << shamt;
            SLT:     port_out = {{(`WORD_W-1){1'b0}}, lt_s};
            SLTU:    port_out = {{(`WORD_W-1){1'b0}}, lt_u};
            XOR:     port_out = port_a ^ port_b;
            SRL:     port_out = port_a >> shamt;
            // Arithmetic shift keeps the sign
            SRA:     port_out = $signed(port_a) >>> shamt;
            OR:      port_out = port_a | port_b;
            AND:     port_out = port_a & port_b;
            default: port_out = '0;
        endcase
    end

endmodule

//--- src/exec_reg_file.sv
// Integer register file
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module exec_reg_file (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [`REG_IDX_W-1:0] rs1,
    input  logic [`REG_IDX_W-1:0] rs2,
    output logic [`WORD_W-1:0]    rs1_data,
    output logic [`WORD_W-1:0]    rs2_data,
    input  logic                  wen,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`WORD_W-1:0]    w_data
);
    logic [`WORD_W-1:0] regs [`NUM_REGS];

    // Single write port, x0 never written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= w_data;
        end
    end

    // No bypass, same-cycle write shows up next cycle
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/exec_decode.sv
// RV32I control unit
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module exec_decode (
    input  logic [`WORD_W-1:0]          instr,
    output logic [`REG_IDX_W-1:0]       rs1,
    output logic [`REG_IDX_W-1:0]       rs2,
    output logic [`REG_IDX_W-1:0]       rd,
    output exec_ctrl_pkg::alu_op_t      alu_op,
    output exec_ctrl_pkg::alu_a_sel_t   alu_a_sel,
    output exec_ctrl_pkg::alu_b_sel_t   alu_b_sel,
    output rv32i_isa_pkg::branch_cond_t branch_cond,
    output logic [`WORD_W-1:0]          imm_i,
    output logic [`WORD_W-1:0]          imm_s,
    output logic [`WORD_W-1:0]          imm_u,
    output logic [`WORD_W-1:0]          imm_b,
    output logic [`WORD_W-1:0]          imm_j,
    output logic                        reg_write,
    output logic                        dren,
    output logic                        dwen,
    output logic                        branch,
    output logic                        jump,
    output logic                        j_sel,
    output logic                        illegal
);
    import rv32i_isa_pkg::*;
    import exec_ctrl_pkg::*;

    opcode_t opcode;
    alu_op_t arith_op;

    assign opcode = opcode_t'(instr[6:0]);

    // Register fields are passed raw, reg_write qualifies rd
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign branch_cond = branch_cond_t'(instr[14:12]);

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 / funct7 to ALU op
    // SUB only exists in the register form
    always_comb begin
        case (instr[14:12])
            3'b000:  arith_op = (opcode == OP && instr[30]) ? SUB : ADD;
            3'b001:  arith_op = SLL;
            3'b010:  arith_op = SLT;
            3'b011:  arith_op = SLTU;
            3'b100:  arith_op = XOR;
            3'b101:  arith_op = instr[30] ? SRA : SRL;
            3'b110:  arith_op = OR;
            default: arith_op = AND;
        endcase
    end

    always_comb begin
        // Defaults describe a no-op
        alu_op    = ADD;
        alu_a_sel = RS1;
        alu_b_sel = RS2;
        reg_write = 1'b0;
        dren      = 1'b0;
        dwen      = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        j_sel     = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            LUI: begin
                alu_a_sel = ZERO;
                alu_b_sel = IMM_U;
                reg_write = 1'b1;
            end
            AUIPC: begin
                alu_a_sel = PC;
                alu_b_sel = IMM_U;
                reg_write = 1'b1;
            end
            JAL, JALR: begin
                jump      = 1'b1;
                j_sel     = (opcode == JAL);
                reg_write = 1'b1;
            end
            BRANCH: branch = 1'b1;
            LOAD: begin
                // Address is rs1 + imm_i
                alu_b_sel = IMM_I;
                dren      = 1'b1;
                reg_write = 1'b1;
            end
            STORE: begin
                alu_b_sel = IMM_S;
                dwen      = 1'b1;
            end
            OP_IMM: begin
                // Shift amount rides in imm_i low bits
                alu_op    = arith_op;
                alu_b_sel = IMM_I;
                reg_write = 1'b1;
            end
            OP: begin
                alu_op    = arith_op;
                reg_write = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- src/exec_ctrl_pkg.sv
// Execute control types
package exec_ctrl_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_t;

    // ALU port A source
    typedef enum logic [1:0] {
        RS1  = 2'd0,
        PC   = 2'd1,
        ZERO = 2'd2
    } alu_a_sel_t;

    // ALU port B source
    typedef enum logic [1:0] {
        RS2   = 2'd0,
        IMM_I = 2'd1,
        IMM_S = 2'd2,
        IMM_U = 2'd3
    } alu_b_sel_t;

endpackage

//--- src/rv32i_isa_pkg.sv
// RV32I ISA types
package rv32i_isa_pkg;

    // Major opcodes of the base integer set
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // Branch conditions
    // Encoded as the branch funct3 field
    // 3'b010 and 3'b011 are unused
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_t;

endpackage

//--- src/rv32i_defs.svh
// RV32I width macros
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// Data and address width
`define WORD_W 32

// Architectural registers
`define NUM_REGS 32

// Register index width
`define REG_IDX_W 5

`endif
